// ==== files.f ====
bpu_pkg.sv
fetch_decode.sv
direction_predictor.sv
target_buffer.sv
return_stack.sv
pred_select.sv
bpu.sv
tb_bpu.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the pass message shows up
verilator --binary --timing -Wno-fatal --top-module tb_bpu -f files.f -o sim_bpu || exit 1
out=$(./obj_dir/sim_bpu) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1

// ==== tb_bpu.sv ====
`timescale 1ns/10ps

module tb_bpu;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 2000;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_CYCLES + 92;   // 2100 with margin

    logic        clk;
    logic        rst;
    logic [31:0] if_pc_i;
    logic [31:0] if_inst_i;
    logic        ex_branch_valid_i;
    logic        ex_branch_taken_i;
    logic [31:0] ex_pc_i;
    logic [31:0] ex_target_i;
    logic [31:0] ex_inst_i;
    logic        id_ras_push_valid_i;
    logic [31:0] id_ras_push_data_i;
    logic        ex_stall_valid_i;
    logic        branch_or_not_o;
    logic [31:0] pdt_pc_o;
    logic        pdt_res_o;
    logic [15:0] history_o;

    // reference model state
    logic [1:0]  bim [512];
    logic        btb_valid [256];
    logic [21:0] btb_tag [256];
    logic [31:0] btb_tgt [256];
    logic [31:0] ras [8];
    int          ras_sp;
    logic [15:0] hist;
    logic        exp_bon;
    logic        exp_res;
    logic [31:0] exp_pc;

    int seed;
    int cycle_cnt;
    int n;
    int reset_errs;
    int pred_errs;
    int hist_errs;

    bpu DUT (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc_i),
        .if_inst_i           (if_inst_i),
        .ex_branch_valid_i   (ex_branch_valid_i),
        .ex_branch_taken_i   (ex_branch_taken_i),
        .ex_pc_i             (ex_pc_i),
        .ex_target_i         (ex_target_i),
        .ex_inst_i           (ex_inst_i),
        .id_ras_push_valid_i (id_ras_push_valid_i),
        .id_ras_push_data_i  (id_ras_push_data_i),
        .ex_stall_valid_i    (ex_stall_valid_i),
        .branch_or_not_o     (branch_or_not_o),
        .pdt_pc_o            (pdt_pc_o),
        .pdt_res_o           (pdt_res_o),
        .history_o           (history_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // 16 index slots, two tags per slot
    function automatic logic [31:0] pool_pc(input logic [31:0] r);
        pool_pc = {21'h000080, r[4], r[3:0], 6'b000000};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("Fail %s: expected %h, actual %h at %0t", name, exp_v, act_v, $time);
    endtask

    task automatic reset_model();
        for (int i = 0; i < 512; i++)
            bim[i] = 2'b01;   // weakly not-taken
        for (int i = 0; i < 256; i++)
            btb_valid[i] = 1'b0;
        ras_sp = 0;
        hist   = '0;
    endtask

    task automatic gen_fetch();
        logic [31:0] r;
        int          kind;
        r       = $random(seed);
        kind    = $unsigned($random(seed)) % 6;
        if_pc_i = pool_pc($random(seed));
        case (kind)
            0: if_inst_i = {r[31:7], r[5] ? 7'b0110011 : 7'b0010011};
            1, 5: if_inst_i = {r[31:7], 7'b1100011};
            2: if_inst_i = {r[31:7], 7'b1101111};
            3: if_inst_i = {r[31:7], 7'b1100111};
            default: if_inst_i = {12'd0, r[0] ? 5'd1 : 5'd5, 3'b000, 5'd0, 7'b1100111};
        endcase
    endtask

    // second half pushes more often so the stack fills up
    task automatic gen_resolve(input bit heavy_push);
        logic [31:0] r;
        logic [31:0] r2;
        r  = $random(seed);
        r2 = $random(seed);
        ex_branch_valid_i   = r[0];
        ex_branch_taken_i   = r[1];
        ex_stall_valid_i    = (r[4:2] == 3'd0);
        id_ras_push_valid_i = heavy_push ? r[5] : (r[7:5] == 3'd0);
        ex_pc_i             = pool_pc($random(seed));
        ex_target_i         = {r2[31:2], 2'b00};
        id_ras_push_data_i  = {r2[15:0], r[31:18], 2'b00};
        case (r[9:8])
            2'd0, 2'd1: ex_inst_i = {12'd0, r[10] ? 5'd1 : 5'd5, 3'b000, 5'd0, 7'b1100111};
            2'd2: ex_inst_i = {r2[31:20], r[10] ? 5'd1 : 5'd7, r2[14:7], 7'b1100111};
            default: ex_inst_i = r2;
        endcase
    endtask

    // expected prediction from the model state before the coming edge
    task automatic predict_expected();
        bpu_pkg::inst_class_e cls;
        logic [31:0] b_off;
        logic [31:0] j_off;
        logic [31:0] pc4;
        logic        dir;
        logic        hit;
        logic        rv;
        logic [31:0] rt;
        logic        push_now;
        b_off = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25], if_inst_i[11:8], 1'b0};
        j_off = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20], if_inst_i[30:21], 1'b0};
        pc4   = if_pc_i + 32'd4;
        case (if_inst_i[6:0])
            7'b1100011: cls = bpu_pkg::CLS_BRANCH;
            7'b1101111: cls = bpu_pkg::CLS_JAL;
            7'b1100111: begin
                if (if_inst_i[11:7] == 5'd0 && if_inst_i[31:20] == 12'd0
                        && (if_inst_i[19:15] == 5'd1 || if_inst_i[19:15] == 5'd5))
                    cls = bpu_pkg::CLS_RET;
                else
                    cls = bpu_pkg::CLS_JALR;
            end
            default: cls = bpu_pkg::CLS_NONE;
        endcase
        dir      = bim[if_pc_i[9:1]][1];
        hit      = btb_valid[if_pc_i[9:2]] && (btb_tag[if_pc_i[9:2]] == if_pc_i[31:10]);
        push_now = id_ras_push_valid_i && !ex_stall_valid_i;
        rv       = push_now || (ras_sp != 0);
        rt       = push_now ? id_ras_push_data_i : ((ras_sp != 0) ? ras[ras_sp-1] : pc4);
        exp_bon  = (cls != bpu_pkg::CLS_NONE);
        exp_res  = 1'b0;
        exp_pc   = pc4;
        case (cls)
            bpu_pkg::CLS_RET: begin
                exp_res = rv;
                exp_pc  = rv ? rt : pc4;
            end
            bpu_pkg::CLS_JAL: begin
                exp_res = 1'b1;
                exp_pc  = hit ? btb_tgt[if_pc_i[9:2]] : if_pc_i + j_off;
            end
            bpu_pkg::CLS_BRANCH: begin
                exp_res = dir;
                if (dir)
                    exp_pc = hit ? btb_tgt[if_pc_i[9:2]] : if_pc_i + b_off;
            end
            bpu_pkg::CLS_JALR: begin
                exp_res = dir;
                if (dir && hit)
                    exp_pc = btb_tgt[if_pc_i[9:2]];
            end
            default: ;
        endcase
    endtask

    // apply the resolve, pop and push sampled at the last edge
    task automatic update_model();
        logic [8:0] bidx;
        logic [7:0] tidx;
        logic [4:0] ex_rs1;
        bidx   = ex_pc_i[9:1];
        tidx   = ex_pc_i[9:2];
        ex_rs1 = ex_inst_i[19:15];
        if (ex_branch_valid_i) begin
            if (ex_branch_taken_i && bim[bidx] != 2'b11)
                bim[bidx] = bim[bidx] + 2'b01;
            else if (!ex_branch_taken_i && bim[bidx] != 2'b00)
                bim[bidx] = bim[bidx] - 2'b01;
            hist = {hist[14:0], ex_branch_taken_i};
            if (ex_branch_taken_i) begin
                btb_valid[tidx] = 1'b1;
                btb_tag[tidx]   = ex_pc_i[31:10];
                btb_tgt[tidx]   = ex_target_i;
            end
        end
        if (ex_branch_valid_i && ex_branch_taken_i && !ex_stall_valid_i
                && ex_inst_i[6:0] == 7'b1100111 && (ex_rs1 == 5'd1 || ex_rs1 == 5'd5)
                && ras_sp > 0)
            ras_sp = ras_sp - 1;
        if (id_ras_push_valid_i && !ex_stall_valid_i && ras_sp < 8) begin
            ras[ras_sp] = id_ras_push_data_i;
            ras_sp      = ras_sp + 1;
        end
    endtask

    initial begin
        seed                = 32'h9777;
        clk                 = 1'b0;
        rst                 = 1'b1;
        if_pc_i             = '0;
        if_inst_i           = '0;
        ex_branch_valid_i   = 1'b0;
        ex_branch_taken_i   = 1'b0;
        ex_pc_i             = '0;
        ex_target_i         = '0;
        ex_inst_i           = '0;
        id_ras_push_valid_i = 1'b0;
        id_ras_push_data_i  = '0;
        ex_stall_valid_i    = 1'b0;
        cycle_cnt           = 0;
        reset_errs          = 0;
        pred_errs           = 0;
        hist_errs           = 0;
        reset_model();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        if (branch_or_not_o !== 1'b0) begin
            report_mismatch("reset_branch_or_not", 32'd0, {31'd0, branch_or_not_o});
            reset_errs++;
        end
        if (pdt_res_o !== 1'b0) begin
            report_mismatch("reset_pdt_res", 32'd0, {31'd0, pdt_res_o});
            reset_errs++;
        end
        if (pdt_pc_o !== 32'd0) begin
            report_mismatch("reset_pdt_pc", 32'd0, pdt_pc_o);
            reset_errs++;
        end
        if (history_o !== 16'd0) begin
            report_mismatch("reset_history", 32'd0, {16'd0, history_o});
            reset_errs++;
        end
        rst = 1'b0;

        for (n = 0; n < NUM_CYCLES; n++) begin
            gen_fetch();
            gen_resolve(n >= NUM_CYCLES / 2);
            predict_expected();
            @(posedge clk);
            #1;
            update_model();
            if (branch_or_not_o !== exp_bon) begin
                report_mismatch("branch_or_not", {31'd0, exp_bon}, {31'd0, branch_or_not_o});
                pred_errs++;
            end
            if (pdt_res_o !== exp_res) begin
                report_mismatch("pdt_res", {31'd0, exp_res}, {31'd0, pdt_res_o});
                pred_errs++;
            end
            if (pdt_pc_o !== exp_pc) begin
                report_mismatch("pdt_pc", exp_pc, pdt_pc_o);
                pred_errs++;
            end
            if (history_o !== hist) begin
                report_mismatch("history", {16'd0, hist}, {16'd0, history_o});
                hist_errs++;
            end
        end

        $display("error counts: reset %0d, prediction %0d, history %0d",
                 reset_errs, pred_errs, hist_errs);
        if (reset_errs + pred_errs + hist_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== bpu.sv ====
`timescale 1ns/10ps

module bpu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [bpu_pkg::XLEN-1:0]     if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0]     if_inst_i,
    input  logic                         ex_branch_valid_i,
    input  logic                         ex_branch_taken_i,
    input  logic [bpu_pkg::XLEN-1:0]     ex_pc_i,
    input  logic [bpu_pkg::XLEN-1:0]     ex_target_i,
    input  logic [bpu_pkg::XLEN-1:0]     ex_inst_i,
    input  logic                         id_ras_push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0]     id_ras_push_data_i,
    input  logic                         ex_stall_valid_i,
    output logic                         branch_or_not_o,
    output logic [bpu_pkg::XLEN-1:0]     pdt_pc_o,
    output logic                         pdt_res_o,
    output logic [bpu_pkg::HIST_LEN-1:0] history_o
);

    bpu_pkg::inst_class_e     inst_class;
    logic [bpu_pkg::XLEN-1:0] pc_plus4;
    logic [bpu_pkg::XLEN-1:0] br_target;
    logic [bpu_pkg::XLEN-1:0] jal_target;
    logic                     dir_taken;
    logic                     btb_hit;
    logic [bpu_pkg::XLEN-1:0] btb_target;
    logic                     ras_valid;
    logic [bpu_pkg::XLEN-1:0] ras_target;

    fetch_decode u_fetch_decode (
        .if_pc_i      (if_pc_i),
        .if_inst_i    (if_inst_i),
        .inst_class_o (inst_class),
        .pc_plus4_o   (pc_plus4),
        .br_target_o  (br_target),
        .jal_target_o (jal_target)
    );

    direction_predictor u_direction_predictor (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pc_i           (ex_pc_i),
        .dir_taken_o       (dir_taken),
        .history_o         (history_o)
    );

    target_buffer u_target_buffer (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pc_i           (ex_pc_i),
        .ex_target_i       (ex_target_i),
        .btb_hit_o         (btb_hit),
        .btb_target_o      (btb_target)
    );

    return_stack u_return_stack (
        .clk                 (clk),
        .rst                 (rst),
        .id_ras_push_valid_i (id_ras_push_valid_i),
        .id_ras_push_data_i  (id_ras_push_data_i),
        .ex_branch_valid_i   (ex_branch_valid_i),
        .ex_branch_taken_i   (ex_branch_taken_i),
        .ex_inst_i           (ex_inst_i),
        .ex_stall_valid_i    (ex_stall_valid_i),
        .ras_valid_o         (ras_valid),
        .ras_target_o        (ras_target)
    );

    pred_select u_pred_select (
        .clk             (clk),
        .rst             (rst),
        .if_pc_i         (if_pc_i),
        .inst_class_i    (inst_class),
        .pc_plus4_i      (pc_plus4),
        .br_target_i     (br_target),
        .jal_target_i    (jal_target),
        .dir_taken_i     (dir_taken),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .ras_valid_i     (ras_valid),
        .ras_target_i    (ras_target),
        .branch_or_not_o (branch_or_not_o),
        .pdt_pc_o        (pdt_pc_o),
        .pdt_res_o       (pdt_res_o)
    );

endmodule

// ==== pred_select.sv ====
`timescale 1ns/10ps

module pred_select (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  bpu_pkg::inst_class_e     inst_class_i,
    input  logic [bpu_pkg::XLEN-1:0] pc_plus4_i,
    input  logic [bpu_pkg::XLEN-1:0] br_target_i,
    input  logic [bpu_pkg::XLEN-1:0] jal_target_i,
    input  logic                     dir_taken_i,
    input  logic                     btb_hit_i,
    input  logic [bpu_pkg::XLEN-1:0] btb_target_i,
    input  logic                     ras_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] ras_target_i,
    output logic                     branch_or_not_o,
    output logic [bpu_pkg::XLEN-1:0] pdt_pc_o,
    output logic                     pdt_res_o
);

    logic                     is_ctrl;
    logic                     taken;
    logic [bpu_pkg::XLEN-1:0] target;

    assign is_ctrl = (inst_class_i != bpu_pkg::CLS_NONE);

    always_comb begin
        taken  = 1'b0;
        target = pc_plus4_i;   // fall-through by default
        case (inst_class_i)
            bpu_pkg::CLS_RET: begin
                taken = ras_valid_i;
                if (ras_valid_i)
                    target = ras_target_i;
            end
            bpu_pkg::CLS_JAL: begin
                taken  = 1'b1;
                target = btb_hit_i ? btb_target_i : jal_target_i;
            end
            bpu_pkg::CLS_BRANCH: begin
                taken = dir_taken_i;
                if (dir_taken_i)
                    target = btb_hit_i ? btb_target_i : br_target_i;
            end
            bpu_pkg::CLS_JALR: begin
                taken = dir_taken_i;
                if (dir_taken_i && btb_hit_i)   // no static target for jalr
                    target = btb_target_i;
            end
            default: ;
        endcase
    end

    // single pipeline boundary of the unit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branch_or_not_o <= 1'b0;
            pdt_res_o       <= 1'b0;
            pdt_pc_o        <= '0;
        end else begin
            branch_or_not_o <= is_ctrl;
            pdt_res_o       <= taken;
            pdt_pc_o        <= target;
        end
    end

endmodule

// ==== return_stack.sv ====
`timescale 1ns/10ps

module return_stack (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     id_ras_push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] id_ras_push_data_i,
    input  logic                     ex_branch_valid_i,
    input  logic                     ex_branch_taken_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_inst_i,
    input  logic                     ex_stall_valid_i,
    output logic                     ras_valid_o,
    output logic [bpu_pkg::XLEN-1:0] ras_target_o
);

    localparam int SLOT_W = bpu_pkg::RAS_PTR_W - 1;   // entry index width

    logic [bpu_pkg::XLEN-1:0] stack_q [bpu_pkg::RAS_DEPTH];

    logic [bpu_pkg::RAS_PTR_W-1:0] sp_q;     // next free slot
    logic [bpu_pkg::RAS_PTR_W-1:0] sp_pop;   // pointer after this cycle's pop
    logic [bpu_pkg::RAS_PTR_W-1:0] sp_next;
    logic [bpu_pkg::RAS_PTR_W-1:0] sp_top;
    logic [4:0]                    ex_rs1;
    logic                          ex_is_ret;
    logic                          push_req;
    logic                          do_pop;
    logic                          do_push;

    assign ex_rs1    = ex_inst_i[19:15];
    assign ex_is_ret = (ex_inst_i[6:0] == bpu_pkg::OP_JALR)
                    && ((ex_rs1 == bpu_pkg::REG_RA) || (ex_rs1 == bpu_pkg::REG_T0));

    // pop first, then push at the popped pointer
    assign do_pop = ex_branch_valid_i && ex_branch_taken_i && !ex_stall_valid_i
                 && ex_is_ret && (sp_q != '0);
    assign sp_pop = do_pop ? sp_q - 1'b1 : sp_q;

    assign push_req = id_ras_push_valid_i && !ex_stall_valid_i;
    assign do_push  = push_req && (sp_pop < bpu_pkg::RAS_PTR_W'(bpu_pkg::RAS_DEPTH));
    assign sp_next  = do_push ? sp_pop + 1'b1 : sp_pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_next;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_pop[SLOT_W-1:0]] <= id_ras_push_data_i;
        end
    end

    // a call pushing right now wins over the stored top
    assign sp_top       = sp_q - 1'b1;
    assign ras_valid_o  = push_req || (sp_q != '0);
    assign ras_target_o = push_req ? id_ras_push_data_i : stack_q[sp_top[SLOT_W-1:0]];

endmodule

// ==== target_buffer.sv ====
`timescale 1ns/10ps

module target_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  logic                     ex_branch_valid_i,
    input  logic                     ex_branch_taken_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] ex_target_i,
    output logic                     btb_hit_o,
    output logic [bpu_pkg::XLEN-1:0] btb_target_o
);

    logic [bpu_pkg::BTB_TAG_W-1:0] tag_q    [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::XLEN-1:0]      target_q [bpu_pkg::BTB_ENTRIES];
    logic [bpu_pkg::BTB_ENTRIES-1:0] valid_q;

    logic [bpu_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BTB_IDX_W-1:0] wr_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0] rd_tag;
    logic [bpu_pkg::BTB_TAG_W-1:0] wr_tag;
    logic                          wr_en;

    assign rd_idx = if_pc_i[bpu_pkg::BTB_IDX_LSB +: bpu_pkg::BTB_IDX_W];
    assign wr_idx = ex_pc_i[bpu_pkg::BTB_IDX_LSB +: bpu_pkg::BTB_IDX_W];
    assign rd_tag = if_pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];
    assign wr_tag = ex_pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];

    // only taken branches allocate
    assign wr_en = ex_branch_valid_i && ex_branch_taken_i;

    assign btb_hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign btb_target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= ex_target_i;
        end
    end

endmodule

// ==== direction_predictor.sv ====
`timescale 1ns/10ps

module direction_predictor (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [bpu_pkg::XLEN-1:0]     if_pc_i,
    input  logic                         ex_branch_valid_i,
    input  logic                         ex_branch_taken_i,
    input  logic [bpu_pkg::XLEN-1:0]     ex_pc_i,
    output logic                         dir_taken_o,
    output logic [bpu_pkg::HIST_LEN-1:0] history_o
);

    logic [1:0] ctr_q [bpu_pkg::BIM_ENTRIES];

    logic [bpu_pkg::BIM_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BIM_IDX_W-1:0] wr_idx;
    logic [1:0]                    ctr_cur;
    logic [1:0]                    ctr_next;
    logic [bpu_pkg::HIST_LEN-1:0]  hist_q;

    assign rd_idx = if_pc_i[bpu_pkg::BIM_IDX_LSB +: bpu_pkg::BIM_IDX_W];
    assign wr_idx = ex_pc_i[bpu_pkg::BIM_IDX_LSB +: bpu_pkg::BIM_IDX_W];

    // msb of the counter is the predicted direction
    assign dir_taken_o = ctr_q[rd_idx][1];

    // saturating step, clamps at 0 and 3
    assign ctr_cur = ctr_q[wr_idx];
    always_comb begin
        ctr_next = ctr_cur;
        if (ex_branch_taken_i) begin
            if (ctr_cur != 2'b11)
                ctr_next = ctr_cur + 2'b01;
        end else begin
            if (ctr_cur != 2'b00)
                ctr_next = ctr_cur - 2'b01;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::BIM_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::CTR_INIT;
            end
        end else if (ex_branch_valid_i) begin
            ctr_q[wr_idx] <= ctr_next;
        end
    end

    // newest outcome enters at bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (ex_branch_valid_i) begin
            hist_q <= {hist_q[bpu_pkg::HIST_LEN-2:0], ex_branch_taken_i};
        end
    end

    assign history_o = hist_q;

endmodule

// ==== fetch_decode.sv ====
`timescale 1ns/10ps

module fetch_decode (
    input  logic [bpu_pkg::XLEN-1:0] if_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] if_inst_i,
    output bpu_pkg::inst_class_e     inst_class_o,
    output logic [bpu_pkg::XLEN-1:0] pc_plus4_o,
    output logic [bpu_pkg::XLEN-1:0] br_target_o,
    output logic [bpu_pkg::XLEN-1:0] jal_target_o
);

    bpu_pkg::opcode_e opcode;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [11:0]      i_imm;
    logic             ret_form;
    logic [bpu_pkg::XLEN-1:0] b_imm;
    logic [bpu_pkg::XLEN-1:0] j_imm;

    assign opcode = bpu_pkg::opcode_e'(if_inst_i[6:0]);
    assign rd     = if_inst_i[11:7];
    assign rs1    = if_inst_i[19:15];
    assign i_imm  = if_inst_i[31:20];

    // jalr x0, 0(ra|t0) is treated as a return
    assign ret_form = (rd == 5'd0)
                   && ((rs1 == bpu_pkg::REG_RA) || (rs1 == bpu_pkg::REG_T0))
                   && (i_imm == 12'd0);

    always_comb begin
        inst_class_o = bpu_pkg::CLS_NONE;
        case (opcode)
            bpu_pkg::OP_BRANCH: inst_class_o = bpu_pkg::CLS_BRANCH;
            bpu_pkg::OP_JAL:    inst_class_o = bpu_pkg::CLS_JAL;
            bpu_pkg::OP_JALR: begin
                inst_class_o = ret_form ? bpu_pkg::CLS_RET : bpu_pkg::CLS_JALR;
            end
            default: ;  // not a control transfer
        endcase
    end

    // sign extended b-type offset
    assign b_imm = {{(bpu_pkg::XLEN-12){if_inst_i[31]}},
                    if_inst_i[7], if_inst_i[30:25], if_inst_i[11:8], 1'b0};

    // sign extended j-type offset
    assign j_imm = {{(bpu_pkg::XLEN-20){if_inst_i[31]}},
                    if_inst_i[19:12], if_inst_i[20], if_inst_i[30:21], 1'b0};

    assign pc_plus4_o   = if_pc_i + 32'd4;
    assign br_target_o  = if_pc_i + b_imm;
    assign jal_target_o = if_pc_i + j_imm;

endmodule

// ==== bpu_pkg.sv ====
package bpu_pkg;

    // datapath width
    localparam int XLEN = 32;

    // global outcome history
    localparam int HIST_LEN = 16;

    // bimodal direction table, indexed by pc[9:1]
    localparam int BIM_ENTRIES = 512;
    localparam int BIM_IDX_W   = 9;
    localparam int BIM_IDX_LSB = 1;
    localparam logic [1:0] CTR_INIT = 2'b01;   // weakly not-taken

    // branch target buffer, index pc[9:2], tag pc[31:10]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = 8;
    localparam int BTB_IDX_LSB = 2;
    localparam int BTB_TAG_W   = 22;

    // return address stack, pointer counts 0..RAS_DEPTH
    localparam int RAS_DEPTH = 8;
    localparam int RAS_PTR_W = 4;

    // link registers used by call/return hints
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_RET
    } inst_class_e;

endpackage
